// File: Bender.yml
package:
  name: qracc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/qracc_pkg.sv
      - rtl/qracc_bus_pkg.sv
      - rtl/qracc_switch_drv.sv
      - rtl/qracc_adc_encoder.sv
      - rtl/qracc_ctrl.sv
      - rtl/qracc_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/qracc_analog_model.sv
      - tb/qracc_props.sv
      - tb/tb_qracc_top.sv

// File: compile.f
+incdir+rtl
rtl/qracc_pkg.sv
rtl/qracc_bus_pkg.sv
rtl/qracc_switch_drv.sv
rtl/qracc_adc_encoder.sv
rtl/qracc_ctrl.sv
rtl/qracc_top.sv
tb/qracc_analog_model.sv
tb/qracc_props.sv
tb/tb_qracc_top.sv

// File: rtl/qracc_adc_encoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Thermometer to signed code encoder, registered
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "qracc_consts.svh"

module qracc_adc_encoder (
    input  logic                                   clk,
    input  logic                                   nrst,
    input  qracc_pkg::therm_t    [`QRACC_COLS-1:0] therm_i,
    output qracc_pkg::adc_code_t [`QRACC_COLS-1:0] codes_o
);
    import qracc_pkg::*;

    typedef logic [`QRACC_ADC_BITS-1:0] level_t;

    localparam level_t MID = (`QRACC_COMP_CNT + 1) / 2;   // Offset to bipolar

    level_t    [`QRACC_COLS-1:0] level;
    adc_code_t [`QRACC_COLS-1:0] codes_q;

    // Highest set comparator gives the count k
    always_comb begin
        for (int c = 0; c < `QRACC_COLS; c++) begin
            level[c] = '0;
            for (int j = 0; j < `QRACC_COMP_CNT; j++) begin
                if (therm_i[c][j]) begin
                    level[c] = level_t'(j + 1);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            codes_q <= '0;
        end else begin
            for (int c = 0; c < `QRACC_COLS; c++) begin
                codes_q[c] <= level[c] - MID;       // k - 8, wraps to signed
            end
        end
    end

    assign codes_o = codes_q;

endmodule

// File: rtl/qracc_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic request and response types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package qracc_bus_pkg;

    typedef logic [11:0] wb_adr_t;  // Byte address, 4 KiB window
    typedef logic [31:0] wb_dat_t;

    // Master to slave
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;   // Write data
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic    ack;   // Single cycle, read data valid with it
        wb_dat_t dat;
    } wb_rsp_t;

endpackage

// File: rtl/qracc_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Array sizes and Wishbone register offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef QRACC_CONSTS_SVH
`define QRACC_CONSTS_SVH

// Analog array geometry
`define QRACC_ROWS      32
`define QRACC_COLS      8

// Column ADC, one signed code per column
`define QRACC_ADC_BITS  4
`define QRACC_COMP_CNT  15          // 2**ADC_BITS - 1 comparators

// Register map, word aligned
`define QRACC_A_WEIGHT  12'h000     // One word per row, row in adr[6:2]
`define QRACC_A_DATA_P  12'h100     // Rows driven to +1
`define QRACC_A_DATA_N  12'h104     // Rows driven to -1
`define QRACC_A_MAC     12'h108     // Write starts a MAC
`define QRACC_A_RESULT  12'h10C     // Packed column codes

`endif

// File: rtl/qracc_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone slave with SRAM and MAC sequencing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "qracc_consts.svh"

module qracc_ctrl (
    input  logic                                     clk,
    input  logic                                     nrst,
    input  qracc_bus_pkg::wb_req_t                   wb_req_i,
    output qracc_bus_pkg::wb_rsp_t                   wb_rsp_o,
    input  qracc_pkg::col_vec_t                      sa_out_i,
    input  qracc_pkg::adc_code_t [`QRACC_COLS-1:0]   adc_codes_i,
    output logic                                     mac_en_o,
    output qracc_pkg::row_vec_t                      data_p_o,
    output qracc_pkg::row_vec_t                      data_n_o,
    output qracc_pkg::to_analog_t                    sram_o
);
    import qracc_pkg::*;
    import qracc_bus_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_PCH, S_WL_WR, S_WL_RD, S_CAPTURE, S_MAC_EVAL, S_MAC_LATCH, S_ACK
    } state_e;

    localparam wb_adr_t   A_WEIGHT   = `QRACC_A_WEIGHT;
    localparam adc_code_t CODE_EMPTY = 4'b1000;   // Empty thermometer, k = 0

    state_e                      state;
    logic                        we_q;
    logic                        mac_en_q;
    logic                        req_valid;
    logic                        hit_weight;
    row_vec_t                    data_p_q;
    row_vec_t                    data_n_q;
    adc_code_t [`QRACC_COLS-1:0] result_q;
    row_addr_t                   row_q;
    col_vec_t                    wr_data_q;
    wb_dat_t                     rdata_q;
    wb_dat_t                     reg_rdata;
    row_vec_t                    wl_onehot;

    assign req_valid  = wb_req_i.cyc && wb_req_i.stb;
    assign hit_weight = (wb_req_i.adr[11:7] == A_WEIGHT[11:7]);

    // Register readback mux, unmapped reads give zero
    always_comb begin
        reg_rdata = '0;
        case (wb_req_i.adr)
            `QRACC_A_DATA_P: reg_rdata = data_p_q;
            `QRACC_A_DATA_N: reg_rdata = data_n_q;
            `QRACC_A_RESULT: reg_rdata = result_q;  // Column c in bits 4c+3:4c
            default:         reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= S_IDLE;
            we_q     <= 1'b0;
            mac_en_q <= 1'b0;
            data_p_q <= '0;
            data_n_q <= '0;
            result_q <= {`QRACC_COLS{CODE_EMPTY}};
        end else begin
            mac_en_q <= 1'b0;                       // One-cycle pulse
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        we_q <= wb_req_i.we;
                        if (hit_weight) begin
                            state <= S_PCH;
                        end else if (wb_req_i.adr == `QRACC_A_MAC && wb_req_i.we) begin
                            state    <= S_MAC_EVAL;
                            mac_en_q <= 1'b1;
                        end else begin
                            state <= S_ACK;
                            if (wb_req_i.we && wb_req_i.adr == `QRACC_A_DATA_P) begin
                                data_p_q <= wb_req_i.dat;
                            end
                            if (wb_req_i.we && wb_req_i.adr == `QRACC_A_DATA_N) begin
                                data_n_q <= wb_req_i.dat;
                            end
                        end
                    end
                end
                S_PCH:       state <= we_q ? S_WL_WR : S_WL_RD;
                S_WL_WR:     state <= S_ACK;
                S_WL_RD:     state <= S_CAPTURE;    // Sense amps resolve
                S_CAPTURE:   state <= S_ACK;
                S_MAC_EVAL:  state <= S_MAC_LATCH;  // Encoder registers at this edge
                S_MAC_LATCH: begin
                    result_q <= adc_codes_i;
                    state    <= S_ACK;
                end
                S_ACK:       state <= S_IDLE;
                default:     state <= S_IDLE;
            endcase
        end
    end

    // Request payload and read data
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            row_q     <= wb_req_i.adr[6:2];
            wr_data_q <= wb_req_i.dat[`QRACC_COLS-1:0];
            rdata_q   <= wb_req_i.we ? '0 : reg_rdata;
        end else if (state == S_CAPTURE) begin
            rdata_q <= wb_dat_t'(sa_out_i);         // Zero above the columns
        end
    end

    // Wordline decode
    always_comb begin
        wl_onehot        = '0;
        wl_onehot[row_q] = 1'b1;
    end

    // SRAM strobes per state
    always_comb begin
        sram_o         = '0;
        sram_o.PCH     = 1'b1;                      // Idle high, not precharging
        sram_o.WR_DATA = wr_data_q;
        case (state)
            S_PCH: sram_o.PCH = 1'b0;
            S_WL_WR: begin
                sram_o.WL    = wl_onehot;
                sram_o.WRITE = 1'b1;
                sram_o.CSEL  = 1'b1;
            end
            S_WL_RD, S_CAPTURE: begin
                sram_o.WL   = wl_onehot;
                sram_o.SAEN = 1'b1;
            end
            default: ;
        endcase
    end

    assign mac_en_o     = mac_en_q;
    assign data_p_o     = data_p_q;
    assign data_n_o     = data_n_q;
    assign wb_rsp_o.ack = (state == S_ACK) && req_valid;
    assign wb_rsp_o.dat = rdata_q;

endmodule

// File: rtl/qracc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Array vector types and analog interface structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "qracc_consts.svh"

package qracc_pkg;

    typedef logic [`QRACC_ROWS-1:0]         row_vec_t;     // One bit per row
    typedef logic [`QRACC_COLS-1:0]         col_vec_t;     // One bit per column
    typedef logic [$clog2(`QRACC_ROWS)-1:0] row_addr_t;    // Row index
    typedef logic [`QRACC_COMP_CNT-1:0]     therm_t;       // Comparator outputs of a column
    typedef logic signed [`QRACC_ADC_BITS-1:0] adc_code_t; // Signed column result

    // Digital to analog, switch matrix and SRAM controls
    typedef struct packed {
        row_vec_t VDR_SEL;      // Row to +1 drive
        row_vec_t VSS_SEL;      // Row to -1 drive
        row_vec_t VRST_SEL;     // Row to reset level
        row_vec_t VDR_SELB;
        row_vec_t VSS_SELB;
        row_vec_t VRST_SELB;
        col_vec_t NF;           // ADC negative feedback
        col_vec_t R2A;
        col_vec_t M2A;
        col_vec_t NFB;
        col_vec_t R2AB;
        col_vec_t M2AB;
        row_vec_t WL;           // One-hot wordline
        col_vec_t WR_DATA;
        logic     WRITE;
        logic     CSEL;
        logic     SAEN;         // Sense amplifier enable
        logic     PCH;          // Precharge, active low
    } to_analog_t;

    // Analog to digital, sense amplifiers and thermometer ADCs
    typedef struct packed {
        col_vec_t                      SA_OUT;
        therm_t [`QRACC_COLS-1:0]      ADC_OUT;
    } from_analog_t;

endpackage

// File: rtl/qracc_switch_drv.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Row switch matrix and ADC phase driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module qracc_switch_drv (
    input  logic                  clk,
    input  logic                  mac_en_i,
    input  qracc_pkg::row_vec_t   data_p_i,
    input  qracc_pkg::row_vec_t   data_n_i,
    output qracc_pkg::to_analog_t sel_o
);
    import qracc_pkg::*;

    logic     rst_phase;
    row_vec_t pos_rows;
    row_vec_t neg_rows;
    row_vec_t zero_rows;

    assign rst_phase = clk && mac_en_i;             // High half of the MAC cycle
    assign pos_rows  = data_p_i & ~data_n_i;
    assign neg_rows  = data_n_i & ~data_p_i;
    assign zero_rows = ~(pos_rows | neg_rows);      // Both or neither set

    always_comb begin
        sel_o = '0;
        if (rst_phase) begin
            sel_o.VDR_SEL  = '0;
            sel_o.VSS_SEL  = '0;
            sel_o.VRST_SEL = '1;                    // All rows to reset
            sel_o.NF       = '1;
            sel_o.R2A      = '1;
            sel_o.M2A      = '0;
        end else begin
            sel_o.VDR_SEL  = pos_rows;
            sel_o.VSS_SEL  = neg_rows;
            sel_o.VRST_SEL = zero_rows;
            sel_o.NF       = '0;
            sel_o.R2A      = '0;
            sel_o.M2A      = '1;                    // Array onto ADC input
        end
        sel_o.VDR_SELB  = ~sel_o.VDR_SEL;
        sel_o.VSS_SELB  = ~sel_o.VSS_SEL;
        sel_o.VRST_SELB = ~sel_o.VRST_SEL;
        sel_o.NFB       = ~sel_o.NF;
        sel_o.R2AB      = ~sel_o.R2A;
        sel_o.M2AB      = ~sel_o.M2A;
    end

endmodule

// File: rtl/qracc_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-memory MAC macro digital top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "qracc_consts.svh"

module qracc_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  qracc_bus_pkg::wb_req_t  wb_req_i,
    output qracc_bus_pkg::wb_rsp_t  wb_rsp_o,
    output qracc_pkg::to_analog_t   to_analog_o,
    input  qracc_pkg::from_analog_t from_analog_i
);
    import qracc_pkg::*;

    logic                        mac_en;
    row_vec_t                    data_p;
    row_vec_t                    data_n;
    to_analog_t                  sram_fields;
    to_analog_t                  sel_fields;
    adc_code_t [`QRACC_COLS-1:0] adc_codes;

    qracc_ctrl u_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .sa_out_i    (from_analog_i.SA_OUT),
        .adc_codes_i (adc_codes),
        .mac_en_o    (mac_en),
        .data_p_o    (data_p),
        .data_n_o    (data_n),
        .sram_o      (sram_fields)
    );

    qracc_switch_drv u_switch_drv (
        .clk      (clk),
        .mac_en_i (mac_en),
        .data_p_i (data_p),
        .data_n_i (data_n),
        .sel_o    (sel_fields)
    );

    qracc_adc_encoder u_adc_encoder (
        .clk     (clk),
        .nrst    (nrst),
        .therm_i (from_analog_i.ADC_OUT),
        .codes_o (adc_codes)
    );

    // Selects and phases from the driver, SRAM fields from the controller
    always_comb begin
        to_analog_o         = sel_fields;
        to_analog_o.WL      = sram_fields.WL;
        to_analog_o.WR_DATA = sram_fields.WR_DATA;
        to_analog_o.WRITE   = sram_fields.WRITE;
        to_analog_o.CSEL    = sram_fields.CSEL;
        to_analog_o.SAEN    = sram_fields.SAEN;
        to_analog_o.PCH     = sram_fields.PCH;
    end

endmodule

// File: tb/qracc_analog_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral array: weights, sense amps, bipolar MAC, ADC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "qracc_consts.svh"

module qracc_analog_model (
    input  logic                    clk,
    input  qracc_pkg::to_analog_t   to_analog_i,
    output qracc_pkg::from_analog_t from_analog_o
);
    import qracc_pkg::*;

    col_vec_t     weights [`QRACC_ROWS];
    row_addr_t    wl_row;
    from_analog_t resp;

    initial begin
        for (int r = 0; r < `QRACC_ROWS; r++) begin
            weights[r] = '0;
        end
    end

    // Active wordline index
    always_comb begin
        wl_row = '0;
        for (int r = 0; r < `QRACC_ROWS; r++) begin
            if (to_analog_i.WL[r]) begin
                wl_row = row_addr_t'(r);
            end
        end
    end

    always @(posedge clk) begin
        if (to_analog_i.WRITE && to_analog_i.CSEL && |to_analog_i.WL) begin
            weights[wl_row] <= to_analog_i.WR_DATA;
        end
    end

    always_comb begin
        int sum;
        int level;
        resp = '0;
        if (to_analog_i.SAEN) begin
            resp.SA_OUT = weights[wl_row];
        end
        for (int c = 0; c < `QRACC_COLS; c++) begin
            sum = 0;
            for (int r = 0; r < `QRACC_ROWS; r++) begin
                if (to_analog_i.VDR_SEL[r]) sum += weights[r][c] ? 1 : -1;
                if (to_analog_i.VSS_SEL[r]) sum -= weights[r][c] ? 1 : -1;
            end
            level = sum >>> 2;                      // Charge sharing scales by four
            level = (level > 7) ? 7 : ((level < -8) ? -8 : level);
            for (int j = 0; j < level + 8; j++) begin
                resp.ADC_OUT[c][j] = 1'b1;          // Thermometer, k = level + 8
            end
        end
    end

    assign #0.5 from_analog_o = resp;               // Comparator settling

endmodule

// File: tb/qracc_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound bus, MAC pulse and row select assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module qracc_props (
    input logic                   clk,
    input logic                   nrst,
    input qracc_bus_pkg::wb_req_t wb_req_i,
    input qracc_bus_pkg::wb_rsp_t wb_rsp_i,
    input qracc_pkg::to_analog_t  to_analog_i,
    input logic                   mac_en_i
);
    int fail_cnt = 0;

    assert property (@(posedge clk) disable iff (!nrst)
        wb_rsp_i.ack |-> wb_req_i.cyc && wb_req_i.stb)
    else begin
        fail_cnt++;
        $error("ack high without an active cycle");
    end

    assert property (@(posedge clk) disable iff (!nrst) mac_en_i |=> !mac_en_i)
    else begin
        fail_cnt++;
        $error("mac_en longer than one cycle");
    end

    assert property (@(posedge clk) disable iff (!nrst)
        (to_analog_i.VDR_SEL & to_analog_i.VSS_SEL) == '0)
    else begin
        fail_cnt++;
        $error("row driven to both rails");
    end

    // Precharge, wordline, capture, then ack
    assert property (@(posedge clk) disable iff (!nrst)
        $rose(wb_req_i.stb) && wb_req_i.cyc && !wb_req_i.we && wb_req_i.adr[11:7] == 5'd0
        |=> !wb_rsp_i.ack [*3] ##1 wb_rsp_i.ack)
    else begin
        fail_cnt++;
        $error("weight read ack not on the fourth edge");
    end

endmodule

bind qracc_top qracc_props u_props (
    .clk         (clk),
    .nrst        (nrst),
    .wb_req_i    (wb_req_i),
    .wb_rsp_i    (wb_rsp_o),
    .to_analog_i (to_analog_o),
    .mac_en_i    (mac_en)
);

// File: tb/tb_qracc_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top with array model, Wishbone access and stimulus table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "qracc_consts.svh"

module tb_qracc_top;
    import qracc_pkg::*;
    import qracc_bus_pkg::*;

    localparam int   CLK_PERIOD = 4;
    localparam int   RST_CYCLES = 3;
    localparam int   ACK_LIMIT  = 20;
    localparam logic OP_WR      = 1'b1;
    localparam logic OP_RD      = 1'b0;

    typedef struct packed {
        logic       op;
        logic [2:0] test;       // Behavior number counted from 1
        wb_adr_t    adr;
        wb_dat_t    dat;
        wb_dat_t    exp;        // Read entries only
    } entry_t;

    logic         clk;
    logic         nrst;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    to_analog_t   to_analog;
    from_analog_t from_analog;

    entry_t   table_q [$];
    col_vec_t shadow_w [`QRACC_ROWS];
    row_vec_t shadow_p;
    row_vec_t shadow_n;
    integer   seed = 32'h2e0a6316;
    int       table_len = 0;
    int       errors = 0;
    int       checks = 0;
    string    test_names [6] = '{"reset result", "weight readback", "input registers",
                                 "random MAC", "saturation", "unmapped access"};

    qracc_top dut (
        .clk           (clk),
        .nrst          (nrst),
        .wb_req_i      (wb_req),
        .wb_rsp_o      (wb_rsp),
        .to_analog_o   (to_analog),
        .from_analog_i (from_analog)
    );

    qracc_analog_model u_array (
        .clk           (clk),
        .to_analog_i   (to_analog),
        .from_analog_o (from_analog)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input wb_dat_t got, input wb_dat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // Classic cycle with stb held through the ack edge
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                             output wb_dat_t rdata, output int latency);
        @(negedge clk);
        wb_req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!wb_rsp.ack && latency < ACK_LIMIT);
        if (!wb_rsp.ack) begin
            errors++;
            $display("No ack from the DUT for address 0x%03h within %0d cycles", adr, latency);
        end
        rdata = wb_rsp.dat;
        @(negedge clk);
        wb_req = '0;
    endtask

    function automatic int ack_latency_for(input logic op, input wb_adr_t adr);
        if (adr[11:7] == 5'd0) return (op == OP_RD) ? 4 : 3;
        if (adr == `QRACC_A_MAC && op == OP_WR) return 3;
        return 1;
    endfunction

    // Bipolar sum per column shifted by two and clamped
    function automatic wb_dat_t expected_result(input row_vec_t p, input row_vec_t n);
        wb_dat_t res;
        int      sum;
        int      code;
        res = '0;
        for (int c = 0; c < `QRACC_COLS; c++) begin
            sum = 0;
            for (int r = 0; r < `QRACC_ROWS; r++) begin
                if (p[r] && !n[r]) sum += shadow_w[r][c] ? 1 : -1;
                if (n[r] && !p[r]) sum -= shadow_w[r][c] ? 1 : -1;
            end
            code = sum >>> 2;
            code = (code > 7) ? 7 : ((code < -8) ? -8 : code);
            res[4*c +: 4] = code[3:0];
        end
        return res;
    endfunction

    function automatic void add_entry(input logic [2:0] test, input logic op,
                                      input wb_adr_t adr, input wb_dat_t dat, input wb_dat_t exp);
        table_q.push_back('{op: op, test: test, adr: adr, dat: dat, exp: exp});
        if (op == OP_WR && adr[11:7] == 5'd0) shadow_w[adr[6:2]] = dat[`QRACC_COLS-1:0];
        if (op == OP_WR && adr == `QRACC_A_DATA_P) shadow_p = dat;
        if (op == OP_WR && adr == `QRACC_A_DATA_N) shadow_n = dat;
    endfunction

    function automatic void add_mac(input logic [2:0] test, input row_vec_t p,
                                    input row_vec_t n, input wb_dat_t exp);
        add_entry(test, OP_WR, `QRACC_A_DATA_P, p, '0);
        add_entry(test, OP_WR, `QRACC_A_DATA_N, n, '0);
        add_entry(test, OP_WR, `QRACC_A_MAC, '0, '0);
        add_entry(test, OP_RD, `QRACC_A_RESULT, '0, exp);
    endfunction

    initial begin
        wb_dat_t  rdata;
        int       latency;
        int       mark;
        row_vec_t p;
        row_vec_t n;
        clk    = 1'b0;
        nrst   = 1'b0;
        wb_req = '0;
        add_entry(1, OP_RD, `QRACC_A_RESULT, '0, 32'h8888_8888);
        for (int r = 0; r < `QRACC_ROWS; r++) add_entry(2, OP_WR, r * 4, $random(seed), '0);
        for (int r = 0; r < `QRACC_ROWS; r++) add_entry(2, OP_RD, r * 4, '0, shadow_w[r]);
        add_entry(3, OP_WR, `QRACC_A_DATA_P, $random(seed), '0);
        add_entry(3, OP_WR, `QRACC_A_DATA_N, $random(seed), '0);
        add_entry(3, OP_RD, `QRACC_A_DATA_P, '0, shadow_p);
        add_entry(3, OP_RD, `QRACC_A_DATA_N, '0, shadow_n);
        repeat (4) begin
            p = $random(seed);
            n = $random(seed);
            add_mac(4, p, n, expected_result(p, n));
        end
        for (int r = 0; r < `QRACC_ROWS; r++) add_entry(5, OP_WR, r * 4, 32'hFF, '0);
        add_mac(5, '1, '0, 32'h7777_7777);
        add_mac(5, '0, '1, 32'h8888_8888);
        add_mac(5, '1, 32'h0000_FFFF, 32'h4444_4444);   // 16 rows at +1 and 16 at 0
        add_entry(6, OP_RD, 12'h180, '0, '0);
        add_entry(6, OP_WR, 12'h200, 32'hA5A5_5A5A, '0);
        add_entry(6, OP_RD, 12'h200, '0, '0);
        table_len = table_q.size();

        repeat (RST_CYCLES) @(negedge clk);
        nrst = 1'b1;
        mark = 0;
        for (int i = 0; i < table_len; i++) begin
            bus_cycle(table_q[i].op, table_q[i].adr, table_q[i].dat, rdata, latency);
            check_value("wb_rsp.ack latency", latency,
                        ack_latency_for(table_q[i].op, table_q[i].adr));
            if (table_q[i].op == OP_RD) begin
                check_value($sformatf("wb_rsp.dat at 0x%03h", table_q[i].adr), rdata,
                            table_q[i].exp);
            end
            if (i == table_len - 1 || table_q[i + 1].test != table_q[i].test) begin
                $display("Test %0d, %s: %0d errors", table_q[i].test,
                         test_names[table_q[i].test - 1], errors - mark);
                mark = errors;
            end
        end

        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 dut.u_props.fail_cnt);
        if (errors == 0 && dut.u_props.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Ten cycles per table entry
    initial begin
        wait (table_len > 0);
        #((RST_CYCLES + table_len * 10) * CLK_PERIOD);
        $display("Watchdog expired before the stimulus table finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
